/* build.f */
+incdir+source
source/interboard_pkg.sv
source/msg_framer.sv
source/word_sender.sv
source/word_receiver.sv
source/msg_assembler.sv
source/interboard_link.sv
dv/interboard_link_sva.sv
dv/interboard_link_tb.sv

/* dv/interboard_link_tb.sv */
`timescale 1ns/100ps
`include "interboard_macros.svh"

module interboard_link_tb;

    typedef struct {
        logic                      err;
        interboard_pkg::msg_type_e mtype;
        logic [`IB_X_W-1:0]        x;
        logic [`IB_Y_W-1:0]        y;
        logic [`IB_CARD_W-1:0]     card;
        logic [`IB_SEL_W-1:0]      sel;
        logic [`IB_DIR_W-1:0]      dir;
    } exp_msg_t;

    logic                      clk;
    logic                      interboard_rst;
    logic                      ctrl_en;
    interboard_pkg::msg_type_e ctrl_msg_type;
    logic [`IB_X_W-1:0]        ctrl_block_x;
    logic [`IB_Y_W-1:0]        ctrl_block_y;
    logic [`IB_CARD_W-1:0]     ctrl_card;
    logic [`IB_SEL_W-1:0]      ctrl_sel_len;
    logic [`IB_DIR_W-1:0]      ctrl_move_dir;
    logic                      ctrl_ready;
    logic                      request_out;
    logic [`IB_WORD_W-1:0]     link_data_out;
    logic                      ack_in;
    logic                      request_in;
    logic [`IB_WORD_W-1:0]     link_data_in;
    logic                      ack_out;
    logic                      msg_valid;
    interboard_pkg::msg_type_e msg_type;
    logic [`IB_X_W-1:0]        msg_block_x;
    logic [`IB_Y_W-1:0]        msg_block_y;
    logic [`IB_CARD_W-1:0]     msg_card;
    logic [`IB_SEL_W-1:0]      msg_sel_len;
    logic [`IB_DIR_W-1:0]      msg_move_dir;
    logic                      rx_error;

    // messages accepted by the framer, oldest first
    exp_msg_t exp_q[$];
    int check_errors = 0;
    int timeout_errors = 0;
    int accepted = 0;
    int received = 0;
    // loopback state
    bit corrupt_y = 1'b0;
    int req_wait;
    int ack_wait;
    int word_cnt;

    interboard_link interboard_link_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // request and data travel together to the receive pins
    always @(posedge clk) begin
        #2;
        if (interboard_rst) begin
            request_in = 1'b0;
            link_data_in = '0;
            req_wait = -1;
            word_cnt = 0;
        end else if (request_in != request_out) begin
            if (req_wait < 0)
                req_wait = $urandom_range(5, 0);
            if (req_wait == 0) begin
                link_data_in = link_data_out;
                // third word is block_y, 3 bits wide
                if (request_out && corrupt_y && word_cnt % `IB_FIELD_COUNT == 2)
                    link_data_in[3] = 1'b1;
                if (request_out)
                    word_cnt++;
                request_in = request_out;
                req_wait = -1;
            end else begin
                req_wait--;
            end
        end
    end

    // ack path back to the sender
    always @(posedge clk) begin
        #2;
        if (interboard_rst) begin
            ack_in = 1'b0;
            ack_wait = -1;
        end else if (ack_in != ack_out) begin
            if (ack_wait < 0)
                ack_wait = $urandom_range(5, 0);
            if (ack_wait == 0) begin
                ack_in = ack_out;
                ack_wait = -1;
            end else begin
                ack_wait--;
            end
        end
    end

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic compare_field(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("** Error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic check_idle_outputs;
        compare_field("ctrl_ready", 1, ctrl_ready);
        compare_field("request_out", 0, request_out);
        compare_field("ack_out", 0, ack_out);
        compare_field("msg_valid", 0, msg_valid);
        compare_field("rx_error", 0, rx_error);
    endtask

    task automatic wait_for_ready;
        int n;
        n = 0;
        while (!ctrl_ready && n < 1000) begin
            next_cycle();
            n++;
        end
        if (!ctrl_ready) begin
            $display("timeout at %0t: ctrl_ready never came back high", $time);
            timeout_errors++;
        end
    endtask

    task automatic wait_drained;
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 4000) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout at %0t: %0d messages never arrived", $time, exp_q.size());
            timeout_errors++;
        end
    endtask

    task automatic send_msg(input interboard_pkg::msg_type_e t, input logic [`IB_X_W-1:0] x,
                            input logic [`IB_Y_W-1:0] y, input logic [`IB_CARD_W-1:0] c,
                            input logic [`IB_SEL_W-1:0] s, input logic [`IB_DIR_W-1:0] d,
                            input logic err);
        exp_msg_t m;
        wait_for_ready();
        ctrl_msg_type = t;
        ctrl_block_x = x;
        ctrl_block_y = y;
        ctrl_card = c;
        ctrl_sel_len = s;
        ctrl_move_dir = d;
        ctrl_en = 1'b1;
        if (ctrl_ready) begin
            m = '{err, t, x, y, c, s, d};
            exp_q.push_back(m);
            accepted++;
        end
        next_cycle();
        ctrl_en = 1'b0;
    endtask

    task automatic send_random(input logic err);
        send_msg(interboard_pkg::msg_type_e'($urandom_range(5, 0)), 5'($urandom),
                 3'($urandom), 6'($urandom), 3'($urandom), 1'($urandom), err);
    endtask

    always @(negedge clk) begin : rx_check
        exp_msg_t want;
        if (msg_valid) begin
            received++;
            if (exp_q.size() == 0) begin
                $display("msg_valid at %0t with no message outstanding", $time);
                check_errors++;
            end else begin
                want = exp_q.pop_front();
                compare_field("msg_type", want.mtype, msg_type);
                compare_field("msg_block_x", want.x, msg_block_x);
                compare_field("msg_block_y", want.y, msg_block_y);
                compare_field("msg_card", want.card, msg_card);
                compare_field("msg_sel_len", want.sel, msg_sel_len);
                compare_field("msg_move_dir", want.dir, msg_move_dir);
                compare_field("rx_error", want.err, rx_error);
            end
        end
    end

    initial begin
        int i;
        int start;
        int n;
        int sva_errors;
        void'($urandom(7613));
        interboard_rst = 1'b1;
        ctrl_en = 1'b0;
        ctrl_msg_type = interboard_pkg::msg_none;
        ctrl_block_x = '0;
        ctrl_block_y = '0;
        ctrl_card = '0;
        ctrl_sel_len = '0;
        ctrl_move_dir = '0;
        ack_in = 1'b0;
        request_in = 1'b0;
        link_data_in = '0;
        repeat (8) next_cycle();
        interboard_rst = 1'b0;
        check_idle_outputs();

        // every opcode, all fields at their maximum
        for (i = 0; i < 6; i++)
            send_msg(interboard_pkg::msg_type_e'(i), '1, '1, '1, '1, '1, 1'b0);
        wait_drained();

        // back to back random traffic
        for (i = 0; i < 30; i++) begin
            send_random(1'b0);
            if (i == 0) begin
                // framer busy, this request must be dropped
                compare_field("ctrl_ready", 0, ctrl_ready);
                ctrl_msg_type = interboard_pkg::msg_end_turn;
                ctrl_card = 6'h2a;
                ctrl_en = 1'b1;
                next_cycle();
                ctrl_en = 1'b0;
            end
        end
        wait_drained();
        compare_field("message count", accepted, received);

        // bad bit on the block_y word, then a clean message
        corrupt_y = 1'b1;
        send_random(1'b1);
        wait_drained();
        corrupt_y = 1'b0;
        send_random(1'b0);
        wait_drained();

        // reset in the middle of a message
        send_random(1'b0);
        start = word_cnt;
        n = 0;
        // hit reset while request_out and ack_out are both high on the third word
        while ((word_cnt < start + 3 || !ack_out) && n < 1000) begin
            next_cycle();
            n++;
        end
        if (word_cnt < start + 3 || !ack_out) begin
            $display("timeout at %0t: third word was never acknowledged", $time);
            timeout_errors++;
        end
        interboard_rst = 1'b1;
        next_cycle();
        next_cycle();
        check_idle_outputs();
        accepted -= exp_q.size();
        exp_q.delete();
        interboard_rst = 1'b0;
        send_random(1'b0);
        wait_drained();
        compare_field("message count", accepted, received);

        repeat (5) next_cycle();
        sva_errors = interboard_link_i.interboard_link_sva_i.fail_count;
        $display("check errors: %0d, timeouts: %0d, assertion failures: %0d",
                 check_errors, timeout_errors, sva_errors);
        if (check_errors + timeout_errors + sva_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* dv/interboard_link_sva.sv */
`timescale 1ns/100ps
`include "interboard_macros.svh"

module interboard_link_sva (
    input logic                  clk,
    input logic                  interboard_rst,
    input logic                  ctrl_ready,
    input logic                  request_out,
    input logic [`IB_WORD_W-1:0] link_data_out,
    input logic                  ack_in,
    input logic                  ack_out,
    input logic                  msg_valid,
    input logic                  rx_error
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    // word must not move under a raised request
    data_stable_a: assert property (@(posedge clk) disable iff (interboard_rst)
        request_out && $past(request_out) |-> link_data_out == $past(link_data_out))
    else begin
        $error("link_data_out changed while request_out was high");
        fail_count++;
    end

    // new word only once the previous ack has gone away
    req_after_ack_a: assert property (@(posedge clk) disable iff (interboard_rst)
        $rose(request_out) |-> !ack_in)
    else begin
        $error("request_out rose while ack_in was still high");
        fail_count++;
    end

    msg_valid_pulse_a: assert property (@(posedge clk) disable iff (interboard_rst)
        msg_valid |=> !msg_valid)
    else begin
        $error("msg_valid held for more than one cycle");
        fail_count++;
    end

    // sync reset, so one edge is enough
    reset_values_a: assert property (@(posedge clk)
        interboard_rst |=> ctrl_ready && !request_out && !ack_out && !msg_valid && !rx_error)
    else begin
        $error("outputs not at reset values after interboard_rst");
        fail_count++;
    end

endmodule

bind interboard_link interboard_link_sva interboard_link_sva_i (
    .clk(clk),
    .interboard_rst(interboard_rst),
    .ctrl_ready(ctrl_ready),
    .request_out(request_out),
    .link_data_out(link_data_out),
    .ack_in(ack_in),
    .ack_out(ack_out),
    .msg_valid(msg_valid),
    .rx_error(rx_error)
);

/* source/interboard_link.sv */
`timescale 1ns/100ps
`include "interboard_macros.svh"

module interboard_link (
    input  logic                       clk,
    input  logic                       interboard_rst,
    // game controller side
    input  logic                       ctrl_en,
    input  interboard_pkg::msg_type_e  ctrl_msg_type,
    input  logic [`IB_X_W-1:0]         ctrl_block_x,
    input  logic [`IB_Y_W-1:0]         ctrl_block_y,
    input  logic [`IB_CARD_W-1:0]      ctrl_card,
    input  logic [`IB_SEL_W-1:0]       ctrl_sel_len,
    input  logic [`IB_DIR_W-1:0]       ctrl_move_dir,
    output logic                       ctrl_ready,
    // pins toward the other board
    output logic                       request_out,
    output logic [`IB_WORD_W-1:0]      link_data_out,
    input  logic                       ack_in,
    // pins from the other board
    input  logic                       request_in,
    input  logic [`IB_WORD_W-1:0]      link_data_in,
    output logic                       ack_out,
    // reassembled message
    output logic                       msg_valid,
    output interboard_pkg::msg_type_e  msg_type,
    output logic [`IB_X_W-1:0]         msg_block_x,
    output logic [`IB_Y_W-1:0]         msg_block_y,
    output logic [`IB_CARD_W-1:0]      msg_card,
    output logic [`IB_SEL_W-1:0]       msg_sel_len,
    output logic [`IB_DIR_W-1:0]       msg_move_dir,
    output logic                       rx_error
);

    // framer to sender
    logic                  word_valid;
    logic                  word_ready;
    logic [`IB_WORD_W-1:0] word_data;
    // receiver to assembler
    logic                  rx_word_valid;
    logic [`IB_WORD_W-1:0] rx_word;

    msg_framer msg_framer_i (
        .clk(clk), .interboard_rst(interboard_rst),
        .ctrl_en(ctrl_en), .ctrl_msg_type(ctrl_msg_type),
        .ctrl_block_x(ctrl_block_x), .ctrl_block_y(ctrl_block_y),
        .ctrl_card(ctrl_card), .ctrl_sel_len(ctrl_sel_len),
        .ctrl_move_dir(ctrl_move_dir), .word_ready(word_ready),
        .ctrl_ready(ctrl_ready), .word_valid(word_valid), .word_data(word_data)
    );

    word_sender word_sender_i (
        .clk(clk), .interboard_rst(interboard_rst),
        .word_valid(word_valid), .word_data(word_data), .ack_in(ack_in),
        .word_ready(word_ready), .request_out(request_out), .link_data_out(link_data_out)
    );

    word_receiver word_receiver_i (
        .clk(clk), .interboard_rst(interboard_rst),
        .request_in(request_in), .link_data_in(link_data_in),
        .ack_out(ack_out), .rx_word_valid(rx_word_valid), .rx_word(rx_word)
    );

    msg_assembler msg_assembler_i (
        .clk(clk), .interboard_rst(interboard_rst),
        .rx_word_valid(rx_word_valid), .rx_word(rx_word),
        .msg_valid(msg_valid), .msg_type(msg_type),
        .msg_block_x(msg_block_x), .msg_block_y(msg_block_y),
        .msg_card(msg_card), .msg_sel_len(msg_sel_len),
        .msg_move_dir(msg_move_dir), .rx_error(rx_error)
    );

endmodule

/* source/msg_assembler.sv */
`timescale 1ns/100ps
`include "interboard_macros.svh"

module msg_assembler (
    input  logic                       clk,
    input  logic                       interboard_rst,
    input  logic                       rx_word_valid,
    input  logic [`IB_WORD_W-1:0]      rx_word,
    output logic                       msg_valid,
    output interboard_pkg::msg_type_e  msg_type,
    output logic [`IB_X_W-1:0]         msg_block_x,
    output logic [`IB_Y_W-1:0]         msg_block_y,
    output logic [`IB_CARD_W-1:0]      msg_card,
    output logic [`IB_SEL_W-1:0]       msg_sel_len,
    output logic [`IB_DIR_W-1:0]       msg_move_dir,
    output logic                       rx_error
);

    // which field the next word belongs to
    logic [2:0] field_idx;
    // sticky over the message
    logic err_flag;
    // current word has bits above its field
    logic word_err;
    logic last_word;

    assign last_word = (field_idx == 3'(`IB_FIELD_COUNT - 1));

    always_comb begin
        case (field_idx)
            3'd0:    word_err = |(rx_word >> `IB_TYPE_W);
            3'd1:    word_err = |(rx_word >> `IB_X_W);
            3'd2:    word_err = |(rx_word >> `IB_Y_W);
            3'd3:    word_err = |(rx_word >> `IB_CARD_W);
            3'd4:    word_err = |(rx_word >> `IB_SEL_W);
            3'd5:    word_err = |(rx_word >> `IB_DIR_W);
            default: word_err = 1'b1;
        endcase
    end

    // field registers, only the low bits of each word are kept
    always_ff @(posedge clk) begin
        if (rx_word_valid) begin
            case (field_idx)
                3'd0: msg_type     <= interboard_pkg::msg_type_e'(rx_word[`IB_TYPE_W-1:0]);
                3'd1: msg_block_x  <= rx_word[`IB_X_W-1:0];
                3'd2: msg_block_y  <= rx_word[`IB_Y_W-1:0];
                3'd3: msg_card     <= rx_word[`IB_CARD_W-1:0];
                3'd4: msg_sel_len  <= rx_word[`IB_SEL_W-1:0];
                3'd5: msg_move_dir <= rx_word[`IB_DIR_W-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (interboard_rst) begin
            field_idx <= '0;
            err_flag  <= 1'b0;
            msg_valid <= 1'b0;
            rx_error  <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            rx_error  <= 1'b0;
            if (rx_word_valid) begin
                if (last_word) begin
                    // message complete, start over
                    msg_valid <= 1'b1;
                    rx_error  <= err_flag | word_err;
                    field_idx <= '0;
                    err_flag  <= 1'b0;
                end else begin
                    field_idx <= field_idx + 3'd1;
                    err_flag  <= err_flag | word_err;
                end
            end
        end
    end

endmodule

/* source/word_receiver.sv */
`timescale 1ns/100ps
`include "interboard_macros.svh"

module word_receiver (
    input  logic                  clk,
    input  logic                  interboard_rst,
    input  logic                  request_in,
    input  logic [`IB_WORD_W-1:0] link_data_in,
    output logic                  ack_out,
    output logic                  rx_word_valid,
    output logic [`IB_WORD_W-1:0] rx_word
);

    interboard_pkg::recv_state_e state;
    // two-flop sync of the remote request
    logic req_meta;
    logic req_sync;

    always_ff @(posedge clk) begin
        if (interboard_rst) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
        end else begin
            req_meta <= request_in;
            req_sync <= req_meta;
        end
    end

    // data has been stable since request rose upstream of the sync
    always_ff @(posedge clk) begin
        if (state == interboard_pkg::rcv_idle && req_sync) begin
            rx_word <= link_data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (interboard_rst) begin
            state         <= interboard_pkg::rcv_idle;
            ack_out       <= 1'b0;
            rx_word_valid <= 1'b0;
        end else begin
            // valid is a single pulse per word
            rx_word_valid <= 1'b0;
            case (state)
                interboard_pkg::rcv_idle: begin
                    if (req_sync) begin
                        state         <= interboard_pkg::rcv_wait_req_down;
                        ack_out       <= 1'b1;
                        rx_word_valid <= 1'b1;
                    end
                end
                interboard_pkg::rcv_wait_req_down: begin
                    if (!req_sync) begin
                        state   <= interboard_pkg::rcv_idle;
                        ack_out <= 1'b0;
                    end
                end
                default: begin
                    state   <= interboard_pkg::rcv_idle;
                    ack_out <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* source/word_sender.sv */
`timescale 1ns/100ps
`include "interboard_macros.svh"

module word_sender (
    input  logic                  clk,
    input  logic                  interboard_rst,
    input  logic                  word_valid,
    input  logic [`IB_WORD_W-1:0] word_data,
    input  logic                  ack_in,
    output logic                  word_ready,
    output logic                  request_out,
    output logic [`IB_WORD_W-1:0] link_data_out
);

    interboard_pkg::send_state_e state;
    // ack comes from the other board's clock domain
    logic ack_meta;
    logic ack_sync;
    logic [`IB_WORD_W-1:0] data_q;

    assign word_ready    = (state == interboard_pkg::snd_idle);
    assign link_data_out = data_q;

    always_ff @(posedge clk) begin
        if (interboard_rst) begin
            ack_meta <= 1'b0;
            ack_sync <= 1'b0;
        end else begin
            ack_meta <= ack_in;
            ack_sync <= ack_meta;
        end
    end

    // word held on the pins for the whole handshake
    always_ff @(posedge clk) begin
        if (word_valid && word_ready) begin
            data_q <= word_data;
        end
    end

    always_ff @(posedge clk) begin
        if (interboard_rst) begin
            state       <= interboard_pkg::snd_idle;
            request_out <= 1'b0;
        end else begin
            case (state)
                interboard_pkg::snd_idle: begin
                    if (word_valid) begin
                        state       <= interboard_pkg::snd_wait_ack_up;
                        request_out <= 1'b1;
                    end
                end
                interboard_pkg::snd_wait_ack_up: begin
                    // other board has the word, release request
                    if (ack_sync) begin
                        state       <= interboard_pkg::snd_wait_ack_down;
                        request_out <= 1'b0;
                    end
                end
                interboard_pkg::snd_wait_ack_down: begin
                    if (!ack_sync) state <= interboard_pkg::snd_idle;
                end
                default: begin
                    state       <= interboard_pkg::snd_idle;
                    request_out <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* source/msg_framer.sv */
`timescale 1ns/100ps
`include "interboard_macros.svh"

module msg_framer (
    input  logic                          clk,
    input  logic                          interboard_rst,
    input  logic                          ctrl_en,
    input  interboard_pkg::msg_type_e     ctrl_msg_type,
    input  logic [`IB_X_W-1:0]            ctrl_block_x,
    input  logic [`IB_Y_W-1:0]            ctrl_block_y,
    input  logic [`IB_CARD_W-1:0]         ctrl_card,
    input  logic [`IB_SEL_W-1:0]          ctrl_sel_len,
    input  logic [`IB_DIR_W-1:0]          ctrl_move_dir,
    input  logic                          word_ready,
    output logic                          ctrl_ready,
    output logic                          word_valid,
    output logic [`IB_WORD_W-1:0]         word_data
);

    interboard_pkg::framer_state_e state;
    // set once the last word has left, wait for the sender to finish it
    logic last_sent;
    logic word_fire;

    // held copy of the message
    interboard_pkg::msg_type_e type_q;
    logic [`IB_X_W-1:0]        x_q;
    logic [`IB_Y_W-1:0]        y_q;
    logic [`IB_CARD_W-1:0]     card_q;
    logic [`IB_SEL_W-1:0]      sel_q;
    logic [`IB_DIR_W-1:0]      dir_q;

    assign ctrl_ready = (state == interboard_pkg::frm_idle);
    assign word_valid = (state != interboard_pkg::frm_idle) && !last_sent;
    assign word_fire  = word_valid && word_ready;

    // capture only on an accepted request
    always_ff @(posedge clk) begin
        if (ctrl_en && ctrl_ready) begin
            type_q <= ctrl_msg_type;
            x_q    <= ctrl_block_x;
            y_q    <= ctrl_block_y;
            card_q <= ctrl_card;
            sel_q  <= ctrl_sel_len;
            dir_q  <= ctrl_move_dir;
        end
    end

    always_ff @(posedge clk) begin
        if (interboard_rst) begin
            state     <= interboard_pkg::frm_idle;
            last_sent <= 1'b0;
        end else begin
            case (state)
                interboard_pkg::frm_idle: if (ctrl_en) state <= interboard_pkg::frm_type;
                interboard_pkg::frm_type: if (word_fire) state <= interboard_pkg::frm_x;
                interboard_pkg::frm_x:    if (word_fire) state <= interboard_pkg::frm_y;
                interboard_pkg::frm_y:    if (word_fire) state <= interboard_pkg::frm_card;
                interboard_pkg::frm_card: if (word_fire) state <= interboard_pkg::frm_sel;
                interboard_pkg::frm_sel:  if (word_fire) state <= interboard_pkg::frm_dir;
                interboard_pkg::frm_dir: begin
                    // back to idle only after the sender is free again
                    if (word_fire) begin
                        last_sent <= 1'b1;
                    end else if (last_sent && word_ready) begin
                        state     <= interboard_pkg::frm_idle;
                        last_sent <= 1'b0;
                    end
                end
                default: state <= interboard_pkg::frm_idle;
            endcase
        end
    end

    // current field, zero extended to the link width
    always_comb begin
        word_data = '0;
        case (state)
            interboard_pkg::frm_type: word_data[`IB_TYPE_W-1:0] = type_q;
            interboard_pkg::frm_x:    word_data[`IB_X_W-1:0]    = x_q;
            interboard_pkg::frm_y:    word_data[`IB_Y_W-1:0]    = y_q;
            interboard_pkg::frm_card: word_data[`IB_CARD_W-1:0] = card_q;
            interboard_pkg::frm_sel:  word_data[`IB_SEL_W-1:0]  = sel_q;
            interboard_pkg::frm_dir:  word_data[`IB_DIR_W-1:0]  = dir_q;
            default:                  word_data = '0;
        endcase
    end

endmodule

/* source/interboard_pkg.sv */
`include "interboard_macros.svh"

package interboard_pkg;

    // message opcodes carried in the msg_type field
    typedef enum logic [`IB_TYPE_W-1:0] {
        msg_none     = 4'd0,
        msg_draw     = 4'd1,
        msg_place    = 4'd2,
        msg_move     = 4'd3,
        msg_select   = 4'd4,
        msg_end_turn = 4'd5
    } msg_type_e;

    // framer, one state per field in send order
    typedef enum logic [2:0] {
        frm_idle,
        frm_type,
        frm_x,
        frm_y,
        frm_card,
        frm_sel,
        frm_dir
    } framer_state_e;

    // sender, four-phase request side
    typedef enum logic [1:0] {
        snd_idle,
        snd_wait_ack_up,
        snd_wait_ack_down
    } send_state_e;

    // receiver, four-phase acknowledge side
    typedef enum logic {
        rcv_idle,
        rcv_wait_req_down
    } recv_state_e;

endpackage

/* source/interboard_macros.svh */
`ifndef INTERBOARD_MACROS_SVH
`define INTERBOARD_MACROS_SVH

// width of one word on the parallel link
`define IB_WORD_W 6

// words per message, one per field
`define IB_FIELD_COUNT 6

// field widths, in link order
`define IB_TYPE_W 4
`define IB_X_W 5
`define IB_Y_W 3
`define IB_CARD_W 6
`define IB_SEL_W 3
`define IB_DIR_W 1

`endif
